//--- design/gfx_pkg.sv
package gfx_pkg;

    // fixed-point coordinate and the records built from it
    typedef logic signed [15:0] coord_t;
    typedef logic [3*$bits(coord_t)-1:0] vertex_t;
    typedef logic [12*$bits(coord_t)-1:0] transform_t;

    // instance 0 is always the camera
    typedef logic [7:0] inst_id_t;

    // local vertex index, three of them per triangle with v0 on top
    typedef logic [7:0] vidx_t;
    typedef logic [3*$bits(vidx_t)-1:0] tri_idx_t;

    typedef logic [12:0] vert_addr_t;
    typedef logic [12:0] tri_addr_t;
    typedef logic [7:0] tri_count_t;

    typedef enum logic [3:0] {
        st_idle,
        st_load_base,
        st_req_tri,
        st_wait_tri,
        st_req_v0,
        st_cap_v0,
        st_cap_v1,
        st_cap_v2,
        st_present,
        st_next_inst,
        st_done
    } frame_state_e;

    typedef enum logic {
        kind_camera,
        kind_triangle
    } setup_kind_e;

    // corner n of a packed triangle, n = 0 selects the upper field
    function automatic vidx_t pick_vidx(tri_idx_t idx, logic [1:0] n);
        case (n)
            2'd0: return idx[3*$bits(vidx_t)-1:2*$bits(vidx_t)];
            2'd1: return idx[2*$bits(vidx_t)-1:$bits(vidx_t)];
            default: return idx[$bits(vidx_t)-1:0];
        endcase
    endfunction

endpackage

//--- design/sync_ram.sv
`timescale 1ns/1ps

module sync_ram #(
    parameter int WIDTH = 24,
    parameter int DEPTH = 8192
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // write port, loaded from outside between frames
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one clock of latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- design/instance_table.sv
`timescale 1ns/1ps

module instance_table #(
    parameter int INST_DEPTH = 256
) (
    input  logic                 clk,
    input  logic                 rst,

    // load side
    input  logic                 we,
    input  gfx_pkg::inst_id_t    waddr,
    input  gfx_pkg::vert_addr_t  wr_vert_base,
    input  gfx_pkg::tri_addr_t   wr_tri_base,
    input  gfx_pkg::tri_count_t  wr_tri_count,
    input  gfx_pkg::transform_t  wr_transform,

    // read side, used by the frame driver
    input  gfx_pkg::inst_id_t    rd_id,
    output gfx_pkg::vert_addr_t  vert_base,
    output gfx_pkg::tri_addr_t   tri_base,
    output gfx_pkg::tri_count_t  tri_count,
    output gfx_pkg::transform_t  transform
);

    localparam int VB_W = $bits(gfx_pkg::vert_addr_t);
    localparam int TB_W = $bits(gfx_pkg::tri_addr_t);
    localparam int TC_W = $bits(gfx_pkg::tri_count_t);
    localparam int TF_W = $bits(gfx_pkg::transform_t);
    localparam int ENTRY_W = VB_W + TB_W + TC_W + TF_W;

    // descriptor and transform kept in one entry per instance
    logic [ENTRY_W-1:0] table_mem [INST_DEPTH];
    logic [ENTRY_W-1:0] rd_entry;

    always_ff @(posedge clk) begin
        if (we) begin
            table_mem[waddr] <= {wr_vert_base, wr_tri_base, wr_tri_count, wr_transform};
        end
    end

    assign rd_entry = table_mem[rd_id];

    // split the entry back into its fields on the registered read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vert_base <= '0;
            tri_base  <= '0;
            tri_count <= '0;
            transform <= '0;
        end else begin
            vert_base <= rd_entry[ENTRY_W-1 -: VB_W];
            tri_base  <= rd_entry[TC_W+TF_W+TB_W-1 -: TB_W];
            tri_count <= rd_entry[TF_W+TC_W-1 -: TC_W];
            transform <= rd_entry[TF_W-1:0];
        end
    end

endmodule

//--- design/frame_driver.sv
`timescale 1ns/1ps

module frame_driver (
    input  logic                   clk,
    input  logic                   rst,

    // frame control
    input  gfx_pkg::inst_id_t      max_inst,
    input  logic                   world_busy,
    output logic                   draw_done,

    // instance table
    output gfx_pkg::inst_id_t      inst_rd_id,
    input  gfx_pkg::vert_addr_t    vert_base,
    input  gfx_pkg::tri_addr_t     tri_base,
    input  gfx_pkg::tri_count_t    tri_count,
    input  gfx_pkg::transform_t    transform,

    // triangle and vertex memories
    output gfx_pkg::tri_addr_t     tri_addr,
    input  gfx_pkg::tri_idx_t      tri_idx,
    output gfx_pkg::vert_addr_t    vert_addr,
    input  gfx_pkg::vertex_t       vert_data,

    // setup records towards the transform stage
    input  logic                   in_ready,
    output logic                   out_valid,
    output gfx_pkg::setup_kind_e   setup_kind,
    output gfx_pkg::inst_id_t      setup_inst,
    output gfx_pkg::vertex_t       setup_v0,
    output gfx_pkg::vertex_t       setup_v1,
    output gfx_pkg::vertex_t       setup_v2,
    output gfx_pkg::transform_t    setup_transform
);

    gfx_pkg::frame_state_e state;

    gfx_pkg::inst_id_t     inst_ctr;
    gfx_pkg::tri_count_t   tri_ctr;
    gfx_pkg::tri_idx_t     idx_r;
    logic [1:0]            corner_sel;
    logic                  last_tri;
    logic                  last_inst;

    // the table is read by the current instance number
    assign inst_rd_id = inst_ctr;

    assign last_tri  = (tri_ctr == tri_count - gfx_pkg::tri_count_t'(1));
    assign last_inst = (inst_ctr >= max_inst);

    // triangle address follows the counter and is sampled by the memory every edge
    assign tri_addr = tri_base + gfx_pkg::tri_addr_t'(tri_ctr);

    // v0 goes out first and v1 and v2 follow while earlier corners return
    always_comb begin
        case (state)
            gfx_pkg::st_cap_v0: corner_sel = 2'd1;
            gfx_pkg::st_cap_v1: corner_sel = 2'd2;
            default:            corner_sel = 2'd0;
        endcase
        vert_addr = vert_base
                  + gfx_pkg::vert_addr_t'(gfx_pkg::pick_vidx(idx_r, corner_sel));
    end

    // control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= gfx_pkg::st_idle;
            inst_ctr  <= '0;
            tri_ctr   <= '0;
            out_valid <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            draw_done <= 1'b0;

            case (state)
                gfx_pkg::st_idle: begin
                    if (!world_busy) begin
                        state <= gfx_pkg::st_load_base;
                    end
                end

                // table read in flight
                gfx_pkg::st_load_base: begin
                    state <= gfx_pkg::st_req_tri;
                end

                // descriptor is valid here and tri_addr goes out this cycle
                gfx_pkg::st_req_tri: begin
                    if (inst_ctr == '0) begin
                        out_valid <= 1'b1;
                        state     <= gfx_pkg::st_present;
                    end else if (tri_count == '0) begin
                        state <= gfx_pkg::st_next_inst;
                    end else begin
                        state <= gfx_pkg::st_wait_tri;
                    end
                end

                gfx_pkg::st_wait_tri: begin
                    state <= gfx_pkg::st_req_v0;
                end

                gfx_pkg::st_req_v0: begin
                    state <= gfx_pkg::st_cap_v0;
                end

                gfx_pkg::st_cap_v0: begin
                    state <= gfx_pkg::st_cap_v1;
                end

                gfx_pkg::st_cap_v1: begin
                    state <= gfx_pkg::st_cap_v2;
                end

                gfx_pkg::st_cap_v2: begin
                    out_valid <= 1'b1;
                    state     <= gfx_pkg::st_present;
                end

                // record held until the transform stage takes it
                gfx_pkg::st_present: begin
                    if (in_ready) begin
                        out_valid <= 1'b0;
                        if (inst_ctr != '0 && !last_tri) begin
                            tri_ctr <= tri_ctr + gfx_pkg::tri_count_t'(1);
                            state   <= gfx_pkg::st_req_tri;
                        end else if (last_inst) begin
                            tri_ctr   <= '0;
                            draw_done <= 1'b1;
                            state     <= gfx_pkg::st_done;
                        end else begin
                            tri_ctr <= '0;
                            state   <= gfx_pkg::st_next_inst;
                        end
                    end
                end

                // only reaches done here when trailing instances were empty
                gfx_pkg::st_next_inst: begin
                    if (last_inst) begin
                        draw_done <= 1'b1;
                        state     <= gfx_pkg::st_done;
                    end else begin
                        inst_ctr <= inst_ctr + gfx_pkg::inst_id_t'(1);
                        state    <= gfx_pkg::st_load_base;
                    end
                end

                gfx_pkg::st_done: begin
                    inst_ctr <= '0;
                    tri_ctr  <= '0;
                    state    <= gfx_pkg::st_idle;
                end

                default: begin
                    state <= gfx_pkg::st_idle;
                end
            endcase
        end
    end

    // record payload is only written while no record is presented
    always_ff @(posedge clk) begin
        case (state)
            gfx_pkg::st_req_tri: begin
                if (inst_ctr == '0) begin
                    setup_kind      <= gfx_pkg::kind_camera;
                    setup_inst      <= inst_ctr;
                    setup_v0        <= '0;
                    setup_v1        <= '0;
                    setup_v2        <= '0;
                    setup_transform <= transform;
                end
            end

            gfx_pkg::st_wait_tri: begin
                idx_r <= tri_idx;
            end

            gfx_pkg::st_cap_v0: begin
                setup_v0 <= vert_data;
            end

            gfx_pkg::st_cap_v1: begin
                setup_v1 <= vert_data;
            end

            gfx_pkg::st_cap_v2: begin
                setup_v2        <= vert_data;
                setup_kind      <= gfx_pkg::kind_triangle;
                setup_inst      <= inst_ctr;
                setup_transform <= transform;
            end

            default: begin
            end
        endcase
    end

endmodule

//--- design/scene_fetch_top.sv
`timescale 1ns/1ps

module scene_fetch_top #(
    parameter int VERT_DEPTH = 8192,
    parameter int TRI_DEPTH  = 8192,
    parameter int INST_DEPTH = 256
) (
    input  logic                   clk,
    input  logic                   rst,

    // instance table load
    input  logic                   inst_we,
    input  gfx_pkg::inst_id_t      inst_waddr,
    input  gfx_pkg::vert_addr_t    inst_vert_base,
    input  gfx_pkg::tri_addr_t     inst_tri_base,
    input  gfx_pkg::tri_count_t    inst_tri_count,
    input  gfx_pkg::transform_t    inst_transform,

    // triangle memory load
    input  logic                   tri_we,
    input  gfx_pkg::tri_addr_t     tri_waddr,
    input  gfx_pkg::tri_idx_t      tri_wdata,

    // vertex memory load
    input  logic                   vert_we,
    input  gfx_pkg::vert_addr_t    vert_waddr,
    input  gfx_pkg::vertex_t       vert_wdata,

    // frame control
    input  gfx_pkg::inst_id_t      max_inst,
    input  logic                   world_busy,
    output logic                   draw_done,

    // setup port
    input  logic                   in_ready,
    output logic                   out_valid,
    output gfx_pkg::setup_kind_e   setup_kind,
    output gfx_pkg::inst_id_t      setup_inst,
    output gfx_pkg::vertex_t       setup_v0,
    output gfx_pkg::vertex_t       setup_v1,
    output gfx_pkg::vertex_t       setup_v2,
    output gfx_pkg::transform_t    setup_transform
);

    gfx_pkg::inst_id_t    inst_rd_id;
    gfx_pkg::vert_addr_t  vert_base;
    gfx_pkg::tri_addr_t   tri_base;
    gfx_pkg::tri_count_t  tri_count;
    gfx_pkg::transform_t  transform;

    gfx_pkg::tri_addr_t   tri_addr;
    gfx_pkg::tri_idx_t    tri_idx;
    gfx_pkg::vert_addr_t  vert_addr;
    gfx_pkg::vertex_t     vert_data;

    instance_table #(
        .INST_DEPTH (INST_DEPTH)
    ) u_inst_table (
        .clk          (clk),
        .rst          (rst),
        .we           (inst_we),
        .waddr        (inst_waddr),
        .wr_vert_base (inst_vert_base),
        .wr_tri_base  (inst_tri_base),
        .wr_tri_count (inst_tri_count),
        .wr_transform (inst_transform),
        .rd_id        (inst_rd_id),
        .vert_base    (vert_base),
        .tri_base     (tri_base),
        .tri_count    (tri_count),
        .transform    (transform)
    );

    // packed vertex indices per triangle
    sync_ram #(
        .WIDTH ($bits(gfx_pkg::tri_idx_t)),
        .DEPTH (TRI_DEPTH)
    ) tri_mem (
        .clk   (clk),
        .we    (tri_we),
        .waddr (tri_waddr),
        .wdata (tri_wdata),
        .raddr (tri_addr),
        .rdata (tri_idx)
    );

    sync_ram #(
        .WIDTH ($bits(gfx_pkg::vertex_t)),
        .DEPTH (VERT_DEPTH)
    ) vert_mem (
        .clk   (clk),
        .we    (vert_we),
        .waddr (vert_waddr),
        .wdata (vert_wdata),
        .raddr (vert_addr),
        .rdata (vert_data)
    );

    frame_driver u_frame_driver (
        .clk             (clk),
        .rst             (rst),
        .max_inst        (max_inst),
        .world_busy      (world_busy),
        .draw_done       (draw_done),
        .inst_rd_id      (inst_rd_id),
        .vert_base       (vert_base),
        .tri_base        (tri_base),
        .tri_count       (tri_count),
        .transform       (transform),
        .tri_addr        (tri_addr),
        .tri_idx         (tri_idx),
        .vert_addr       (vert_addr),
        .vert_data       (vert_data),
        .in_ready        (in_ready),
        .out_valid       (out_valid),
        .setup_kind      (setup_kind),
        .setup_inst      (setup_inst),
        .setup_v0        (setup_v0),
        .setup_v1        (setup_v1),
        .setup_v2        (setup_v2),
        .setup_transform (setup_transform)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 8.0
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk = ~clk;
        end
    end

endmodule

//--- test/scene_fetch_tb.sv
`timescale 1ns/1ps

module scene_fetch_tb;

    localparam int NUM_INST   = 5;
    localparam int NUM_TRI    = 9;
    localparam int NUM_TESTS  = 6;
    localparam int VERT_SPAN  = 32;
    localparam int TIMEOUT    = 3000;
    localparam int IDLE_WATCH = 12;

    typedef logic [359:0] wide_t;

    logic clk;
    logic rst;
    logic inst_we;
    gfx_pkg::inst_id_t inst_waddr;
    gfx_pkg::vert_addr_t inst_vert_base;
    gfx_pkg::tri_addr_t inst_tri_base;
    gfx_pkg::tri_count_t inst_tri_count;
    gfx_pkg::transform_t inst_transform;
    logic tri_we;
    gfx_pkg::tri_addr_t tri_waddr;
    gfx_pkg::tri_idx_t tri_wdata;
    logic vert_we;
    gfx_pkg::vert_addr_t vert_waddr;
    gfx_pkg::vertex_t vert_wdata;
    gfx_pkg::inst_id_t max_inst;
    logic world_busy;
    logic draw_done;
    logic in_ready;
    logic out_valid;
    gfx_pkg::setup_kind_e setup_kind;
    gfx_pkg::inst_id_t setup_inst;
    gfx_pkg::vertex_t setup_v0;
    gfx_pkg::vertex_t setup_v1;
    gfx_pkg::vertex_t setup_v2;
    gfx_pkg::transform_t setup_transform;
    logic [344:0] live_rec;

    // scene with one column per instance and an empty instance 2
    gfx_pkg::vert_addr_t scene_vbase [NUM_INST] = '{13'd0, 13'd100, 13'd300, 13'd2000, 13'd8100};
    gfx_pkg::tri_addr_t scene_tbase [NUM_INST] = '{13'd0, 13'd16, 13'd40, 13'd64, 13'd8000};
    gfx_pkg::tri_count_t scene_tcount [NUM_INST] = '{8'd0, 8'd3, 8'd0, 8'd2, 8'd4};
    logic [15:0] scene_tpat [NUM_INST] = '{16'h1357, 16'h2001, 16'h0bad, 16'h7e11, 16'h4c4c};
    // corner indices of instances 1, 3 and 4 in that order
    gfx_pkg::tri_idx_t scene_tris [NUM_TRI] = '{24'h000102, 24'h02011f, 24'h100a05,
        24'h030303, 24'h1e1d1c, 24'h000010, 24'h0f0e0d, 24'h071f00, 24'h050607};

    // in_ready mode 0 is always ready, 1 drops at random and 2 stalls for long stretches
    gfx_pkg::inst_id_t case_max_inst [NUM_TESTS] = '{8'd4, 8'd4, 8'd0, 8'd2, 8'd3, 8'd4};
    int case_mode [NUM_TESTS] = '{0, 1, 1, 0, 2, 2};

    gfx_pkg::setup_kind_e exp_kind [$];
    gfx_pkg::inst_id_t exp_inst [$];
    gfx_pkg::vertex_t exp_v0 [$];
    gfx_pkg::vertex_t exp_v1 [$];
    gfx_pkg::vertex_t exp_v2 [$];
    gfx_pkg::transform_t exp_xf [$];

    int test_errors;
    int total_errors;
    int tests_failed;
    int tests_run;
    bit timed_out;

    tb_clock #(.PERIOD(8.0)) u_clock (.clk(clk));

    scene_fetch_top #(
        .VERT_DEPTH (8192),
        .TRI_DEPTH  (8192),
        .INST_DEPTH (256)
    ) DUT (
        .clk (clk), .rst (rst),
        .inst_we (inst_we), .inst_waddr (inst_waddr), .inst_vert_base (inst_vert_base),
        .inst_tri_base (inst_tri_base), .inst_tri_count (inst_tri_count),
        .inst_transform (inst_transform),
        .tri_we (tri_we), .tri_waddr (tri_waddr), .tri_wdata (tri_wdata),
        .vert_we (vert_we), .vert_waddr (vert_waddr), .vert_wdata (vert_wdata),
        .max_inst (max_inst), .world_busy (world_busy), .draw_done (draw_done),
        .in_ready (in_ready), .out_valid (out_valid), .setup_kind (setup_kind),
        .setup_inst (setup_inst), .setup_v0 (setup_v0), .setup_v1 (setup_v1),
        .setup_v2 (setup_v2), .setup_transform (setup_transform)
    );

    assign live_rec = {setup_kind, setup_inst, setup_v0, setup_v1, setup_v2, setup_transform};

    // vertex contents follow the full address
    function automatic gfx_pkg::vertex_t vert_fill(int addr);
        logic [15:0] a;
        a = 16'(addr);
        return {a * 16'd3 + 16'd1, a ^ 16'h5a5a, ~a};
    endfunction

    function automatic gfx_pkg::transform_t xform_fill(logic [15:0] pat);
        gfx_pkg::transform_t t;
        for (int k = 0; k < 12; k++) begin
            t[16*k +: 16] = pat * 16'(k + 1) ^ 16'(k << 12);
        end
        return t;
    endfunction

    // position of an instance's first triangle in scene_tris
    function automatic int first_tri(int inst);
        int sum;
        sum = 0;
        for (int i = 1; i < inst; i++) begin
            sum += int'(scene_tcount[i]);
        end
        return sum;
    endfunction

    task automatic report_mismatch(input string name, input wide_t exp_val, input wide_t act_val);
        $display("[ERROR] t=%0t %s expected=%0h actual=%0h", $time, name, exp_val, act_val);
        test_errors++;
    endtask

    task automatic load_scene();
        gfx_pkg::tri_idx_t idx;
        for (int i = 0; i < NUM_INST; i++) begin
            @(negedge clk);
            inst_we        = 1'b1;
            inst_waddr     = gfx_pkg::inst_id_t'(i);
            inst_vert_base = scene_vbase[i];
            inst_tri_base  = scene_tbase[i];
            inst_tri_count = scene_tcount[i];
            inst_transform = xform_fill(scene_tpat[i]);
        end
        @(negedge clk);
        inst_we = 1'b0;
        for (int i = 1; i < NUM_INST; i++) begin
            for (int t = 0; t < int'(scene_tcount[i]); t++) begin
                idx       = scene_tris[first_tri(i) + t];
                tri_we    = 1'b1;
                tri_waddr = gfx_pkg::tri_addr_t'(int'(scene_tbase[i]) + t);
                tri_wdata = idx;
                @(negedge clk);
            end
            tri_we = 1'b0;
            for (int v = 0; v < VERT_SPAN; v++) begin
                vert_we    = 1'b1;
                vert_waddr = gfx_pkg::vert_addr_t'(int'(scene_vbase[i]) + v);
                vert_wdata = vert_fill(int'(scene_vbase[i]) + v);
                @(negedge clk);
            end
            vert_we = 1'b0;
        end
    endtask

    // reference walker yields the camera first and then every triangle of instances 1 to max_i
    task automatic build_expected(input int max_i);
        gfx_pkg::tri_idx_t idx;
        int vb;
        exp_kind.delete();
        exp_inst.delete();
        exp_v0.delete();
        exp_v1.delete();
        exp_v2.delete();
        exp_xf.delete();
        exp_kind.push_back(gfx_pkg::kind_camera);
        exp_inst.push_back(8'd0);
        exp_v0.push_back('0);
        exp_v1.push_back('0);
        exp_v2.push_back('0);
        exp_xf.push_back(xform_fill(scene_tpat[0]));
        for (int i = 1; i <= max_i; i++) begin
            vb = int'(scene_vbase[i]);
            for (int t = 0; t < int'(scene_tcount[i]); t++) begin
                idx = scene_tris[first_tri(i) + t];
                exp_kind.push_back(gfx_pkg::kind_triangle);
                exp_inst.push_back(gfx_pkg::inst_id_t'(i));
                exp_v0.push_back(vert_fill(vb + int'(idx[23:16])));
                exp_v1.push_back(vert_fill(vb + int'(idx[15:8])));
                exp_v2.push_back(vert_fill(vb + int'(idx[7:0])));
                exp_xf.push_back(xform_fill(scene_tpat[i]));
            end
        end
    endtask

    task automatic run_frame(input int tc);
        int cycles;
        int stall_left;
        bit done_seen;
        bit prev_hold;
        logic [344:0] prev_rec;
        build_expected(int'(case_max_inst[tc]));
        test_errors = 0;
        cycles      = 0;
        stall_left  = 0;
        done_seen   = 1'b0;
        prev_hold   = 1'b0;
        prev_rec    = '0;
        tests_run++;
        @(negedge clk);
        max_inst   = case_max_inst[tc];
        world_busy = 1'b0;
        @(negedge clk);
        world_busy = 1'b1;
        while (!done_seen && cycles < TIMEOUT) begin
            // a stalled record must not move
            if (prev_hold) begin
                if (out_valid !== 1'b1) begin
                    report_mismatch("out_valid", wide_t'(1'b1), wide_t'(out_valid));
                end
                if (live_rec !== prev_rec) begin
                    report_mismatch("setup record", wide_t'(prev_rec), wide_t'(live_rec));
                end
            end
            if (draw_done === 1'b1) begin
                done_seen = 1'b1;
                if (exp_kind.size() != 0) begin
                    $display("draw_done came with %0d records still missing", exp_kind.size());
                    test_errors++;
                end
            end else begin
                if (case_mode[tc] == 0) begin
                    in_ready = 1'b1;
                end else if (case_mode[tc] == 1) begin
                    in_ready = ($urandom_range(0, 3) != 0);
                end else if (stall_left > 0) begin
                    in_ready = 1'b0;
                    stall_left--;
                end else begin
                    in_ready   = 1'b1;
                    stall_left = $urandom_range(1, 9);
                end
                // transfer happens on the coming rising edge
                if (out_valid === 1'b1 && in_ready) begin
                    if (exp_kind.size() == 0) begin
                        $display("extra record from instance %0d after the last one", setup_inst);
                        test_errors++;
                    end else begin
                        if (setup_kind !== exp_kind[0]) begin
                            report_mismatch("setup_kind", wide_t'(exp_kind[0]), wide_t'(setup_kind));
                        end
                        if (setup_inst !== exp_inst[0]) begin
                            report_mismatch("setup_inst", wide_t'(exp_inst[0]), wide_t'(setup_inst));
                        end
                        if (setup_v0 !== exp_v0[0]) begin
                            report_mismatch("setup_v0", wide_t'(exp_v0[0]), wide_t'(setup_v0));
                        end
                        if (setup_v1 !== exp_v1[0]) begin
                            report_mismatch("setup_v1", wide_t'(exp_v1[0]), wide_t'(setup_v1));
                        end
                        if (setup_v2 !== exp_v2[0]) begin
                            report_mismatch("setup_v2", wide_t'(exp_v2[0]), wide_t'(setup_v2));
                        end
                        if (setup_transform !== exp_xf[0]) begin
                            report_mismatch("setup_transform", wide_t'(exp_xf[0]),
                                            wide_t'(setup_transform));
                        end
                        void'(exp_kind.pop_front());
                        void'(exp_inst.pop_front());
                        void'(exp_v0.pop_front());
                        void'(exp_v1.pop_front());
                        void'(exp_v2.pop_front());
                        void'(exp_xf.pop_front());
                    end
                end
                prev_hold = (out_valid === 1'b1) && !in_ready;
                prev_rec  = live_rec;
                @(negedge clk);
                cycles++;
            end
        end
        if (!done_seen) begin
            $display("timeout in test %0d, draw_done not seen within %0d cycles", tc, TIMEOUT);
            test_errors++;
            timed_out = 1'b1;
        end else begin
            // with world_busy high the driver must stay quiet
            in_ready = 1'b1;
            for (int w = 0; w < IDLE_WATCH; w++) begin
                @(negedge clk);
                if (out_valid !== 1'b0) begin
                    report_mismatch("out_valid", wide_t'(1'b0), wide_t'(out_valid));
                end
                if (draw_done !== 1'b0) begin
                    report_mismatch("draw_done", wide_t'(1'b0), wide_t'(draw_done));
                end
            end
        end
        $display("test %0d max_inst=%0d mode=%0d done in %0d cycles, %0d errors",
                 tc, case_max_inst[tc], case_mode[tc], cycles, test_errors);
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(86));
        total_errors   = 0;
        tests_failed   = 0;
        tests_run      = 0;
        test_errors    = 0;
        timed_out      = 1'b0;
        rst            = 1'b1;
        inst_we        = 1'b0;
        inst_waddr     = '0;
        inst_vert_base = '0;
        inst_tri_base  = '0;
        inst_tri_count = '0;
        inst_transform = '0;
        tri_we         = 1'b0;
        tri_waddr      = '0;
        tri_wdata      = '0;
        vert_we        = 1'b0;
        vert_waddr     = '0;
        vert_wdata     = '0;
        max_inst       = '0;
        world_busy     = 1'b1;
        in_ready       = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        load_scene();
        for (int tc = 0; tc < NUM_TESTS && !timed_out; tc++) begin
            run_frame(tc);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
design/gfx_pkg.sv
design/sync_ram.sv
design/instance_table.sv
design/frame_driver.sv
design/scene_fetch_top.sv
test/tb_clock.sv
test/scene_fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the scene fetch testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module scene_fetch_tb \
        -f build.f -o scene_fetch_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/scene_fetch_sim); then
    echo "$sim_out"
    echo "simulation exited with a failing status"
    exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
